// File: filelist.f
+incdir+hw
hw/isaPkg.sv
hw/pipePkg.sv
hw/pipeReg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/apbMaster.sv
hw/apbTimeout.sv
hw/proc.sv
tb/proc_assertions.sv
tb/proc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = proc_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/proc_tb.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_tb;

   localparam int W = `PROC_DATA_W;
   localparam int numRandom = 8;
   localparam int progLen = 20;
   localparam int maxWait = 3;
   localparam int numTests = numRandom + 4;
   // worst case per instruction is a memory access with waits plus a bubble and a flush
   localparam int cyclesPerInstr = 4 + maxWait + 3;
   localparam int cycleLimit =
      numTests * (40 + (progLen + 1) * cyclesPerInstr) + `APB_TIMEOUT + 10;

   logic         clk;
   logic         arstN;
   logic [W-1:0] instrAddr;
   logic [W-1:0] instr;
   logic [W-1:0] paddr;
   logic         psel;
   logic         penable;
   logic         pwrite;
   logic [W-1:0] pwdata;
   logic [W-1:0] prdata;
   logic         pready;
   logic         halted;
   logic         err;

   logic [W-1:0] prog [256];
   logic [W-1:0] slaveMem [logic [W-1:0]];
   logic [W-1:0] modelMem [logic [W-1:0]];
   logic [W-1:0] expAddr [$];
   logic [W-1:0] expData [$];
   logic [31:0]  lfsrState;
   int           forcedWait;
   int           waitLeft;
   int           storeCount;
   int           expCount;
   int           errorCount;
   int           failedTests;
   int           cycleCount;

   proc i_proc (
      .clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .halted(halted), .err(err)
   );

   // instruction port answers in the same cycle
   assign instr = prog[instrAddr[7:0]];

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // taps 32, 22, 2, 1
   function automatic logic [15:0] randBits(int n);
      logic [15:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         val = {val[14:0], fb};
      end
      return val;
   endfunction

   // untouched data memory reads back a rotated, scrambled address
   function automatic logic [W-1:0] fillWord(logic [W-1:0] addr);
      return {addr[6:0], addr[15:7]} ^ 16'h5ac3;
   endfunction

   function automatic logic [W-1:0] rType(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                           logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [W-1:0] iType(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                           logic [5:0] imm6);
      return {op, rd, rs, imm6};
   endfunction

   function automatic logic [W-1:0] jType(logic [3:0] op, logic [2:0] rd, logic [8:0] imm9);
      return {op, rd, imm9};
   endfunction

   task automatic clearProgram();
      for (int i = 0; i < 256; i++) begin
         prog[i] = jType(isaPkg::OP_HALT, 3'd0, 9'd0);
      end
   endtask

   task automatic makeRandomProgram(int len);
      logic [3:0] op;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      int         room;
      clearProgram();
      for (int i = 0; i < len; i++) begin
         op = 4'(randBits(4) % 9);
         rd = 3'(randBits(3));
         rs = 3'(randBits(3));
         rt = 3'(randBits(3));
         // forward jumps land at or before the HALT slot
         room = len - i - 1;
         case (op)
            isaPkg::OP_LI:   prog[i] = jType(op, rd, 9'(randBits(9)));
            isaPkg::OP_BEQZ: prog[i] = jType(op, rd, 9'(int'(randBits(3)) % (room + 1)));
            isaPkg::OP_ADDI, isaPkg::OP_LD, isaPkg::OP_ST: begin
               prog[i] = iType(op, rd, rs, 6'(randBits(6)));
            end
            default:         prog[i] = rType(op, rd, rs, rt);
         endcase
      end
   endtask

   task automatic loadForwardProgram();
      clearProgram();
      prog[0]  = jType(isaPkg::OP_LI, 3'd1, 9'd5);
      prog[1]  = jType(isaPkg::OP_LI, 3'd2, 9'd3);
      // back-to-back dependents pull from X/M and M/W
      prog[2]  = rType(isaPkg::OP_ADD, 3'd3, 3'd1, 3'd2);
      prog[3]  = rType(isaPkg::OP_SUB, 3'd4, 3'd3, 3'd1);
      prog[4]  = rType(isaPkg::OP_XOR, 3'd5, 3'd4, 3'd3);
      prog[5]  = iType(isaPkg::OP_ST, 3'd5, 3'd0, 6'd2);
      prog[6]  = iType(isaPkg::OP_LD, 3'd6, 3'd0, 6'd2);
      prog[7]  = rType(isaPkg::OP_ADD, 3'd7, 3'd6, 3'd6);
      prog[8]  = iType(isaPkg::OP_ST, 3'd7, 3'd1, 6'd1);
      prog[9]  = iType(isaPkg::OP_LD, 3'd2, 3'd3, 6'h3f);
      // load result used as store data
      prog[10] = iType(isaPkg::OP_ST, 3'd2, 3'd0, 6'd9);
      prog[11] = rType(isaPkg::OP_AND, 3'd3, 3'd2, 3'd7);
      prog[12] = iType(isaPkg::OP_ST, 3'd3, 3'd0, 6'd10);
   endtask

   task automatic loadBranchProgram();
      clearProgram();
      prog[0]  = jType(isaPkg::OP_LI, 3'd1, 9'd0);
      prog[1]  = jType(isaPkg::OP_LI, 3'd2, 9'd7);
      // taken branch flushes both stores behind it
      prog[2]  = jType(isaPkg::OP_BEQZ, 3'd1, 9'd2);
      prog[3]  = iType(isaPkg::OP_ST, 3'd2, 3'd0, 6'd20);
      prog[4]  = iType(isaPkg::OP_ST, 3'd2, 3'd0, 6'd21);
      prog[5]  = jType(isaPkg::OP_BEQZ, 3'd2, 9'd1);
      prog[6]  = iType(isaPkg::OP_ST, 3'd2, 3'd0, 6'd22);
      prog[7]  = iType(isaPkg::OP_ADDI, 3'd3, 3'd2, 6'h39);
      // zero arrives by forwarding
      prog[8]  = jType(isaPkg::OP_BEQZ, 3'd3, 9'd1);
      prog[9]  = iType(isaPkg::OP_ST, 3'd2, 3'd0, 6'd23);
      prog[10] = iType(isaPkg::OP_ST, 3'd2, 3'd0, 6'd24);
   endtask

   task automatic loadTimeoutProgram();
      clearProgram();
      prog[0] = jType(isaPkg::OP_LI, 3'd1, 9'd4);
      prog[1] = iType(isaPkg::OP_ST, 3'd1, 3'd0, 6'd3);
   endtask

   task automatic loadIllegalProgram();
      clearProgram();
      prog[0] = jType(isaPkg::OP_LI, 3'd1, 9'd1);
      prog[1] = 16'h9000;
      prog[2] = iType(isaPkg::OP_ST, 3'd1, 3'd0, 6'd5);
   endtask

   // ISA-level reference that runs the program in order and records the stores
   task automatic runModel();
      logic [W-1:0] regs [8];
      logic [W-1:0] pc;
      logic [W-1:0] word;
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] d;
      logic [W-1:0] addr;
      logic [W-1:0] imm6;
      logic [W-1:0] imm9;
      logic         done;
      int           steps;
      expAddr.delete();
      expData.delete();
      modelMem.delete();
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      pc = '0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         word = prog[pc[7:0]];
         a = regs[word[8:6]];
         b = regs[word[5:3]];
         d = regs[word[11:9]];
         imm6 = {{10{word[5]}}, word[5:0]};
         imm9 = {{7{word[8]}}, word[8:0]};
         addr = a + imm6;
         pc = pc + 16'd1;
         case (word[15:12])
            isaPkg::OP_ADD:  regs[word[11:9]] = a + b;
            isaPkg::OP_SUB:  regs[word[11:9]] = a - b;
            isaPkg::OP_AND:  regs[word[11:9]] = a & b;
            isaPkg::OP_XOR:  regs[word[11:9]] = a ^ b;
            isaPkg::OP_ADDI: regs[word[11:9]] = addr;
            isaPkg::OP_LI:   regs[word[11:9]] = imm9;
            isaPkg::OP_LD: begin
               regs[word[11:9]] = modelMem.exists(addr) ? modelMem[addr] : fillWord(addr);
            end
            isaPkg::OP_ST: begin
               modelMem[addr] = d;
               expAddr.push_back(addr);
               expData.push_back(d);
            end
            isaPkg::OP_BEQZ: begin
               if (d == '0) begin
                  pc = pc + imm9;
               end
            end
            isaPkg::OP_HALT: done = 1'b1;
            // illegal codes change no state
            default: ;
         endcase
         steps++;
      end
      expCount = expAddr.size();
   endtask

   task automatic answerRead();
      pready <= 1'b1;
      prdata <= slaveMem.exists(paddr) ? slaveMem[paddr] : fillWord(paddr);
   endtask

   task automatic checkStore(logic [W-1:0] addr, logic [W-1:0] data);
      storeCount++;
      slaveMem[addr] = data;
      assert (expAddr.size() > 0) else begin
         $display("unexpected APB write of %h to address %h", data, addr);
         errorCount++;
      end
      if (expAddr.size() > 0) begin
         assert (addr == expAddr[0]) else begin
            $display("FAILED paddr: got %h, expected %h", addr, expAddr[0]);
            errorCount++;
         end
         assert (data == expData[0]) else begin
            $display("FAILED pwdata: got %h, expected %h", data, expData[0]);
            errorCount++;
         end
         void'(expAddr.pop_front());
         void'(expData.pop_front());
      end
   endtask

   // APB slave memory
   always @(posedge clk) begin
      if (!arstN) begin
         pready <= 1'b0;
         waitLeft = 0;
      end else if (psel && !penable) begin
         assert (!halted) else begin
            $display("APB transfer to %h started after halt", paddr);
            errorCount++;
         end
         waitLeft = (forcedWait >= 0) ? forcedWait : int'(randBits(2));
         if (waitLeft == 0) begin
            answerRead();
         end
      end else if (psel && penable) begin
         if (pready) begin
            pready <= 1'b0;
            if (pwrite) begin
               checkStore(paddr, pwdata);
            end
         end else begin
            waitLeft--;
            if (waitLeft == 0) begin
               answerRead();
            end
         end
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("run stopped after %0d cycles without finishing", cycleCount);
         $display("test failed");
         $finish;
      end
   end

   task automatic applyReset();
      @(posedge clk);
      arstN <= 1'b0;
      repeat (5) @(posedge clk);
      arstN <= 1'b1;
      @(negedge clk);
   endtask

   // err must rise while the slave still holds pready low
   task automatic checkTimeout();
      while ((psel && penable) !== 1'b1) @(negedge clk);
      assert (err === 1'b0) else begin
         $display("FAILED err: got %h, expected 0 at start of access", err);
         errorCount++;
      end
      while (pready !== 1'b1) @(negedge clk);
      assert (err === 1'b1) else begin
         $display("FAILED err: got %h, expected 1 before pready", err);
         errorCount++;
      end
   endtask

   task automatic runTest(string name, int waitCycles, logic errExpected);
      int errorsBefore;
      errorsBefore = errorCount;
      forcedWait = waitCycles;
      runModel();
      slaveMem.delete();
      storeCount = 0;
      applyReset();
      assert ({psel, penable, halted, err} === 4'b0000) else begin
         $display("FAILED reset state psel/penable/halted/err: got %h, expected 0",
                  {psel, penable, halted, err});
         errorCount++;
      end
      if (waitCycles > maxWait) begin
         checkTimeout();
      end
      while (halted !== 1'b1) @(negedge clk);
      // watch for late transfers after halt
      repeat (8) @(negedge clk);
      assert (storeCount == expCount) else begin
         $display("FAILED store count: got %h, expected %h", storeCount, expCount);
         errorCount++;
      end
      assert (halted === 1'b1) else begin
         $display("FAILED halted: got %h, expected 1", halted);
         errorCount++;
      end
      assert (err === errExpected) else begin
         $display("FAILED err: got %h, expected %h", err, errExpected);
         errorCount++;
      end
      if (errorCount == errorsBefore) begin
         $display("%s: ok", name);
      end else begin
         failedTests++;
         $display("%s: %0d errors", name, errorCount - errorsBefore);
      end
   endtask

   initial begin
      lfsrState = 32'h3dc77409;
      arstN = 1'b0;
      pready = 1'b0;
      prdata = '0;
      forcedWait = -1;
      waitLeft = 0;
      storeCount = 0;
      expCount = 0;
      errorCount = 0;
      failedTests = 0;
      cycleCount = 0;
      clearProgram();
      for (int t = 0; t < numRandom; t++) begin
         makeRandomProgram(progLen);
         runTest($sformatf("random program %0d", t), -1, 1'b0);
      end
      loadForwardProgram();
      runTest("forwarding and load-use", -1, 1'b0);
      loadBranchProgram();
      runTest("branch flush", -1, 1'b0);
      loadTimeoutProgram();
      runTest("apb wait timeout", `APB_TIMEOUT + 5, 1'b1);
      loadIllegalProgram();
      runTest("illegal opcode", -1, 1'b1);
      errorCount += i_proc.apbChecks.failCount;
      $display("tests run: %0d, failing tests: %0d, errors: %0d",
               numTests, failedTests, errorCount);
      if (errorCount == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: tb/proc_assertions.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_assertions (
   input logic                    clk,
   input logic                    arstN,
   input logic                    psel,
   input logic                    penable,
   input logic                    pwrite,
   input logic [`PROC_DATA_W-1:0] paddr,
   input logic [`PROC_DATA_W-1:0] pwdata,
   input logic                    err
);

   int failCount = 0;

   // access phase only after a setup cycle
   setupFirst: assert property (@(posedge clk) disable iff (!arstN)
      $rose(penable) |-> $past(psel))
      else begin
         failCount++;
         $error("penable rose without a preceding setup cycle");
      end

   // request fields frozen while the slave is waiting
   stableAccess: assert property (@(posedge clk) disable iff (!arstN)
      (psel && penable) |-> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
      else begin
         failCount++;
         $error("paddr, pwrite or pwdata changed during the access phase");
      end

   enableInSel: assert property (@(posedge clk) disable iff (!arstN)
      penable |-> psel)
      else begin
         failCount++;
         $error("penable high while psel is low");
      end

   // sticky error that only reset clears
   errSticky: assert property (@(posedge clk)
      $fell(err) |-> !arstN)
      else begin
         failCount++;
         $error("err fell outside of reset");
      end

endmodule

bind proc proc_assertions apbChecks (
   .clk(clk),
   .arstN(arstN),
   .psel(psel),
   .penable(penable),
   .pwrite(pwrite),
   .paddr(paddr),
   .pwdata(pwdata),
   .err(err)
);

// File: hw/proc.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module proc (
   input  logic                    clk,
   input  logic                    arstN,
   output logic [`PROC_DATA_W-1:0] instrAddr,
   input  logic [`PROC_DATA_W-1:0] instr,
   output logic [`PROC_DATA_W-1:0] paddr,
   output logic                    psel,
   output logic                    penable,
   output logic                    pwrite,
   output logic [`PROC_DATA_W-1:0] pwdata,
   input  logic [`PROC_DATA_W-1:0] prdata,
   input  logic                    pready,
   output logic                    halted,
   output logic                    err
);

   pipePkg::fdPayloadT      fdD;
   pipePkg::fdPayloadT      fdQ;
   pipePkg::dxPayloadT      dxD;
   pipePkg::dxPayloadT      dxQ;
   pipePkg::xmPayloadT      xmD;
   pipePkg::xmPayloadT      xmQ;
   pipePkg::mwPayloadT      mwD;
   pipePkg::mwPayloadT      mwQ;
   logic                    memBusy;
   logic                    loadUse;
   logic                    branchTaken;
   logic [`PROC_DATA_W-1:0] branchTarget;
   logic                    illegal;
   logic                    illegalSeen;
   logic                    accessWait;
   logic                    timeout;

   fetch fetchStage (
      .clk(clk), .arstN(arstN),
      .stall(memBusy || loadUse),
      .branchTaken(branchTaken), .branchTarget(branchTarget),
      .haltSeen(mwQ.valid && mwQ.halt),
      .instrAddr(instrAddr), .instr(instr),
      .fdOut(fdD), .halted(halted)
   );

   pipeReg #(.payloadT(pipePkg::fdPayloadT)) fdReg (
      .clk(clk), .arstN(arstN), .hold(memBusy || loadUse), .flush(branchTaken),
      .d(fdD), .q(fdQ)
   );

   decode decodeStage (
      .clk(clk), .arstN(arstN), .hold(memBusy),
      .fdIn(fdQ), .mwIn(mwQ),
      .dxLoadDest(dxQ.dest), .dxLoadValid(dxQ.valid && dxQ.memRd),
      .dxOut(dxD), .loadUse(loadUse), .illegal(illegal)
   );

   // a load-use stall leaves a bubble behind the load
   pipeReg #(.payloadT(pipePkg::dxPayloadT)) dxReg (
      .clk(clk), .arstN(arstN), .hold(memBusy), .flush(branchTaken || loadUse),
      .d(dxD), .q(dxQ)
   );

   execute executeStage (
      .dxIn(dxQ), .xmFwd(xmQ), .mwFwd(mwQ),
      .xmOut(xmD), .branchTaken(branchTaken), .branchTarget(branchTarget)
   );

   pipeReg #(.payloadT(pipePkg::xmPayloadT)) xmReg (
      .clk(clk), .arstN(arstN), .hold(memBusy), .flush(1'b0),
      .d(xmD), .q(xmQ)
   );

   apbMaster memStage (
      .clk(clk), .arstN(arstN), .xmIn(xmQ),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
      .prdata(prdata), .pready(pready),
      .mwOut(mwD), .memBusy(memBusy), .accessWait(accessWait)
   );

   pipeReg #(.payloadT(pipePkg::mwPayloadT)) mwReg (
      .clk(clk), .arstN(arstN), .hold(memBusy), .flush(1'b0),
      .d(mwD), .q(mwQ)
   );

   apbTimeout apbTimer (
      .clk(clk), .arstN(arstN), .accessWait(accessWait), .timeout(timeout)
   );

   // set as the illegal instruction moves into execute, unless squashed
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         illegalSeen <= 1'b0;
      end else if (illegal && !branchTaken) begin
         illegalSeen <= 1'b1;
      end
   end

   assign err = illegalSeen || timeout;

endmodule

`default_nettype wire

// File: hw/apbTimeout.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module apbTimeout (
   input  logic clk,
   input  logic arstN,
   input  logic accessWait,
   output logic timeout
);

   localparam int cntW = $clog2(`APB_TIMEOUT + 1);
   localparam logic [cntW-1:0] limit = cntW'(`APB_TIMEOUT - 1);

   logic [cntW-1:0] waitCnt;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         waitCnt <= '0;
         timeout <= 1'b0;
      end else begin
         // counts consecutive waits only and saturates at the limit
         if (!accessWait) begin
            waitCnt <= '0;
         end else if (waitCnt != limit) begin
            waitCnt <= waitCnt + 1'b1;
         end
         if (accessWait && waitCnt == limit) begin
            timeout <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/apbMaster.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module apbMaster (
   input  logic                    clk,
   input  logic                    arstN,
   input  pipePkg::xmPayloadT      xmIn,
   output logic [`PROC_DATA_W-1:0] paddr,
   output logic                    psel,
   output logic                    penable,
   output logic                    pwrite,
   output logic [`PROC_DATA_W-1:0] pwdata,
   input  logic [`PROC_DATA_W-1:0] prdata,
   input  logic                    pready,
   output pipePkg::mwPayloadT      mwOut,
   output logic                    memBusy,
   output logic                    accessWait
);

   pipePkg::apbStateT state;
   logic              memOp;
   logic              start;

   assign memOp = xmIn.valid && (xmIn.memRd || xmIn.memWr);
   assign start = (state == pipePkg::IDLE) && memOp;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= pipePkg::IDLE;
      end else begin
         case (state)
            pipePkg::IDLE:   state <= memOp ? pipePkg::SETUP : pipePkg::IDLE;
            pipePkg::SETUP:  state <= pipePkg::ACCESS;
            pipePkg::ACCESS: state <= pready ? pipePkg::IDLE : pipePkg::ACCESS;
            default:         state <= pipePkg::IDLE;
         endcase
      end
   end

   // request fields are captured once and stay put until the transfer ends
   always_ff @(posedge clk) begin
      if (start) begin
         paddr  <= xmIn.result;
         pwrite <= xmIn.memWr;
         pwdata <= xmIn.storeData;
      end
   end

   assign psel       = state != pipePkg::IDLE;
   assign penable    = state == pipePkg::ACCESS;
   assign accessWait = (state == pipePkg::ACCESS) && !pready;
   // low in the completing cycle so the result moves on
   assign memBusy    = start || (state == pipePkg::SETUP) || accessWait;

   always_comb begin
      mwOut.valid = xmIn.valid;
      mwOut.value = xmIn.memRd ? prdata : xmIn.result;
      mwOut.dest  = xmIn.dest;
      mwOut.regWe = xmIn.regWe;
      mwOut.halt  = xmIn.halt;
   end

endmodule

`default_nettype wire

// File: hw/execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module execute (
   input  pipePkg::dxPayloadT      dxIn,
   input  pipePkg::xmPayloadT      xmFwd,
   input  pipePkg::mwPayloadT      mwFwd,
   output pipePkg::xmPayloadT      xmOut,
   output logic                    branchTaken,
   output logic [`PROC_DATA_W-1:0] branchTarget
);

   localparam int W = `PROC_DATA_W;

   logic [W-1:0] opA;
   logic [W-1:0] opB;
   logic [W-1:0] aluB;
   logic [W-1:0] aluRes;
   logic         useImm;
   logic         isHalt;

   // youngest producer first and a load's address is never forwarded
   function automatic logic [W-1:0] fwd(isaPkg::regIdxT idx, logic [W-1:0] regVal);
      if (xmFwd.valid && xmFwd.regWe && !xmFwd.memRd && xmFwd.dest == idx) begin
         return xmFwd.result;
      end else if (mwFwd.valid && mwFwd.regWe && mwFwd.dest == idx) begin
         return mwFwd.value;
      end
      return regVal;
   endfunction

   assign opA    = fwd(dxIn.srcA, dxIn.opA);
   assign opB    = fwd(dxIn.srcB, dxIn.opB);
   assign useImm = dxIn.opcode inside {isaPkg::OP_ADDI, isaPkg::OP_LD, isaPkg::OP_ST};
   assign aluB   = useImm ? dxIn.imm : opB;
   assign isHalt = dxIn.opcode == isaPkg::OP_HALT;

   always_comb begin
      case (dxIn.aluOp)
         isaPkg::ALU_SUB: aluRes = opA - aluB;
         isaPkg::ALU_AND: aluRes = opA & aluB;
         isaPkg::ALU_XOR: aluRes = opA ^ aluB;
         default:         aluRes = opA + aluB;
      endcase
   end

   always_comb begin
      xmOut.valid     = dxIn.valid;
      xmOut.result    = (dxIn.opcode == isaPkg::OP_LI) ? dxIn.imm : aluRes;
      xmOut.storeData = opB;
      xmOut.dest      = dxIn.dest;
      xmOut.regWe     = dxIn.regWe;
      xmOut.memRd     = dxIn.memRd;
      xmOut.memWr     = dxIn.memWr;
      xmOut.halt      = isHalt;
   end

   // HALT also squashes the younger instructions and refetches itself
   assign branchTaken  = dxIn.valid && ((dxIn.branch && opB == '0) || isHalt);
   assign branchTarget = isHalt ? dxIn.pc : dxIn.pc + 1'b1 + dxIn.imm;

endmodule

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module decode (
   input  logic               clk,
   input  logic               arstN,
   input  logic               hold,
   input  pipePkg::fdPayloadT fdIn,
   input  pipePkg::mwPayloadT mwIn,
   input  isaPkg::regIdxT     dxLoadDest,
   input  logic               dxLoadValid,
   output pipePkg::dxPayloadT dxOut,
   output logic               loadUse,
   output logic               illegal
);

   localparam int W = `PROC_DATA_W;

   logic [W-1:0]   regs [`PROC_NUM_REGS];
   isaPkg::opcodeT op;
   isaPkg::aluOpT  aluOp;
   isaPkg::regIdxT srcA;
   isaPkg::regIdxT srcB;
   logic [W-1:0]   imm;
   logic           regWe;
   logic           memRd;
   logic           memWr;
   logic           branch;
   logic           useA;
   logic           useB;
   logic           badOp;

   // a read of the register being written back sees the new value
   function automatic logic [W-1:0] readReg(isaPkg::regIdxT idx);
      if (mwIn.valid && mwIn.regWe && mwIn.dest == idx) begin
         return mwIn.value;
      end
      return regs[idx];
   endfunction

   assign op   = fdIn.instr.r.op;
   assign srcA = fdIn.instr.r.rs;

   always_comb begin
      regWe  = 1'b0;
      memRd  = 1'b0;
      memWr  = 1'b0;
      branch = 1'b0;
      useA   = 1'b0;
      useB   = 1'b0;
      badOp  = 1'b0;
      aluOp  = isaPkg::ALU_ADD;
      srcB   = fdIn.instr.r.rt;
      imm    = {{(W - 6){fdIn.instr.i.imm6[5]}}, fdIn.instr.i.imm6};
      case (op)
         isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND, isaPkg::OP_XOR: begin
            regWe = 1'b1;
            useA  = 1'b1;
            useB  = 1'b1;
            aluOp = isaPkg::aluOpT'(op[1:0]);
         end
         isaPkg::OP_ADDI: begin
            regWe = 1'b1;
            useA  = 1'b1;
         end
         isaPkg::OP_LI: begin
            regWe = 1'b1;
            imm   = {{(W - 9){fdIn.instr.j.imm9[8]}}, fdIn.instr.j.imm9};
         end
         isaPkg::OP_LD: begin
            regWe = 1'b1;
            memRd = 1'b1;
            useA  = 1'b1;
         end
         isaPkg::OP_ST: begin
            memWr = 1'b1;
            useA  = 1'b1;
            useB  = 1'b1;
            srcB  = fdIn.instr.r.rd;
         end
         isaPkg::OP_BEQZ: begin
            branch = 1'b1;
            useB   = 1'b1;
            srcB   = fdIn.instr.r.rd;
            imm    = {{(W - 9){fdIn.instr.j.imm9[8]}}, fdIn.instr.j.imm9};
         end
         isaPkg::OP_HALT: begin
         end
         // illegal codes flow on as a no-op
         default: badOp = 1'b1;
      endcase
   end

   always_comb begin
      dxOut.valid  = fdIn.valid;
      dxOut.opcode = op;
      dxOut.aluOp  = aluOp;
      dxOut.dest   = fdIn.instr.r.rd;
      dxOut.regWe  = regWe;
      dxOut.memRd  = memRd;
      dxOut.memWr  = memWr;
      dxOut.branch = branch;
      dxOut.srcA   = srcA;
      dxOut.srcB   = srcB;
      dxOut.opA    = readReg(srcA);
      dxOut.opB    = readReg(srcB);
      dxOut.imm    = imm;
      dxOut.pc     = fdIn.pc;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `PROC_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (mwIn.valid && mwIn.regWe) begin
         regs[mwIn.dest] <= mwIn.value;
      end
   end

   // load in execute feeding a source used here
   assign loadUse = fdIn.valid && dxLoadValid &&
                    ((useA && srcA == dxLoadDest) || (useB && srcB == dxLoadDest));

   assign illegal = fdIn.valid && badOp && !hold;

endmodule

`default_nettype wire

// File: hw/fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module fetch (
   input  logic                    clk,
   input  logic                    arstN,
   input  logic                    stall,
   input  logic                    branchTaken,
   input  logic [`PROC_DATA_W-1:0] branchTarget,
   input  logic                    haltSeen,
   output logic [`PROC_DATA_W-1:0] instrAddr,
   input  logic [`PROC_DATA_W-1:0] instr,
   output pipePkg::fdPayloadT      fdOut,
   output logic                    halted
);

   localparam int W = `PROC_DATA_W;

   logic [W-1:0] pc;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc     <= W'(`PROC_RESET_PC);
         halted <= 1'b0;
      end else begin
         if (haltSeen) begin
            halted <= 1'b1;
         end
         // a redirect waits while the pipeline is frozen
         if (!halted && !haltSeen && !stall) begin
            pc <= branchTaken ? branchTarget : pc + 1'b1;
         end
      end
   end

   assign instrAddr   = pc;
   assign fdOut.valid = !halted;
   assign fdOut.pc    = pc;
   assign fdOut.instr = instr;

endmodule

`default_nettype wire

// File: hw/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    arstN,
   input  logic    hold,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   // hold wins over flush so a frozen stage keeps its instruction
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         q <= '0;
      end else if (!hold) begin
         // an all-zero payload is a bubble with valid low
         q <= flush ? payloadT'('0) : d;
      end
   end

endmodule

`default_nettype wire

// File: hw/pipePkg.sv
`include "proc_defs.svh"

package pipePkg;

   typedef struct packed {
      logic                    valid;
      logic [`PROC_DATA_W-1:0] pc;
      isaPkg::instrT           instr;
   } fdPayloadT;

   typedef struct packed {
      logic                    valid;
      isaPkg::opcodeT          opcode;
      isaPkg::aluOpT           aluOp;
      isaPkg::regIdxT          dest;
      logic                    regWe;
      logic                    memRd;
      logic                    memWr;
      logic                    branch;
      isaPkg::regIdxT          srcA;
      isaPkg::regIdxT          srcB;
      logic [`PROC_DATA_W-1:0] opA;
      logic [`PROC_DATA_W-1:0] opB;
      logic [`PROC_DATA_W-1:0] imm;
      logic [`PROC_DATA_W-1:0] pc;
   } dxPayloadT;

   // result holds the memory address for loads and stores
   typedef struct packed {
      logic                    valid;
      logic [`PROC_DATA_W-1:0] result;
      logic [`PROC_DATA_W-1:0] storeData;
      isaPkg::regIdxT          dest;
      logic                    regWe;
      logic                    memRd;
      logic                    memWr;
      logic                    halt;
   } xmPayloadT;

   typedef struct packed {
      logic                    valid;
      logic [`PROC_DATA_W-1:0] value;
      isaPkg::regIdxT          dest;
      logic                    regWe;
      logic                    halt;
   } mwPayloadT;

   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } apbStateT;

endpackage

// File: hw/isaPkg.sv
package isaPkg;

   // instruction bits 15 to 12 where unlisted codes are illegal
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_XOR  = 4'd3,
      OP_ADDI = 4'd4,
      OP_LI   = 4'd5,
      OP_LD   = 4'd6,
      OP_ST   = 4'd7,
      OP_BEQZ = 4'd8,
      OP_HALT = 4'd15
   } opcodeT;

   typedef logic [2:0] regIdxT;

   // low opcode bits of the register ops map straight onto this
   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } aluOpT;

   // register, imm6 and imm9 layouts of one instruction word
   typedef struct packed {
      opcodeT     op;
      regIdxT     rd;
      regIdxT     rs;
      regIdxT     rt;
      logic [2:0] unused;
   } rFormT;

   typedef struct packed {
      opcodeT     op;
      regIdxT     rd;
      regIdxT     rs;
      logic [5:0] imm6;
   } iFormT;

   typedef struct packed {
      opcodeT     op;
      regIdxT     rd;
      logic [8:0] imm9;
   } jFormT;

   typedef union packed {
      rFormT r;
      iFormT i;
      jFormT j;
   } instrT;

endpackage

// File: hw/proc_defs.svh
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// data path and instruction width
`define PROC_DATA_W 16
// architectural register count
`define PROC_NUM_REGS 8
// first fetch address after reset
`define PROC_RESET_PC 0
// access-phase wait cycles tolerated before err is raised
`define APB_TIMEOUT 15

`endif
